// File: design/constGen.sv
// --------------------------------------------------
// R2/R3 constant generator
// --------------------------------------------------
`include "regOperand_macros.svh"

module constGen
   import regOperandPkg::*;
(
   input  regNum_t            srcReg,
   input  addrMode_t          as,
   output logic [`DATA_W-1:0] constVal,
   output logic               constValid
);

   always_comb
   begin
      constVal   = '0;
      constValid = 1'b0;
      if (srcReg == `REG_SR)
      begin
         // Mode 00 reads SR itself
         case (as)
            2'b01:
            begin
               constVal   = '0;
               constValid = 1'b1;
            end
            2'b10:
            begin
               constVal   = `DATA_W'(4);
               constValid = 1'b1;
            end
            2'b11:
            begin
               constVal   = `DATA_W'(8);
               constValid = 1'b1;
            end
            default:
               constValid = 1'b0;
         endcase
      end
      else if (srcReg == `REG_CG2)
      begin
         // Every R3 mode is a constant
         constValid = 1'b1;
         case (as)
            2'b00:   constVal = '0;
            2'b01:   constVal = `DATA_W'(1);
            2'b10:   constVal = `DATA_W'(2);
            default: constVal = '1;
         endcase
      end
   end

endmodule

// File: design/instrFieldDecode.sv
// --------------------------------------------------
// Instruction field decoder for register numbers,
// addressing mode and byte flag per format
// --------------------------------------------------
module instrFieldDecode
   import regOperandPkg::*;
(
   input  instrWord_t  instr,
   output operandReq_t req
);

   localparam logic [5:0] SINGLE_OP_PREFIX = 6'b000100;
   localparam logic [2:0] JUMP_PREFIX = 3'b001;

   logic isSingleOp;
   logic isJump;

   assign isSingleOp = (instr.singleOp.prefix == SINGLE_OP_PREFIX);
   assign isJump = (instr.dualOp.opcode[3:1] == JUMP_PREFIX);

   always_comb
   begin
      req = '0;
      if (isSingleOp)
      begin
         // One register serves as source and destination
         req.srcReg    = instr.singleOp.regNum;
         req.dstReg    = instr.singleOp.regNum;
         req.as        = instr.singleOp.as;
         req.byteMode  = instr.singleOp.byteFlag;
         req.hasSource = 1'b1;
         req.hasDest   = 1'b1;
      end
      else if (isJump)
      begin
         // Jumps carry an offset and no register operands
         req.hasSource = 1'b0;
         req.hasDest   = 1'b0;
      end
      else
      begin
         req.srcReg    = instr.dualOp.srcReg;
         req.dstReg    = instr.dualOp.dstReg;
         req.as        = instr.dualOp.as;
         req.byteMode  = instr.dualOp.byteFlag;
         req.hasSource = 1'b1;
         req.hasDest   = 1'b1;
      end
   end

endmodule

// File: design/operandSelect.sv
// --------------------------------------------------
// Operand selector that merges register words and
// constants and applies byte mode and format gating
// --------------------------------------------------
`include "regOperand_macros.svh"

module operandSelect
   import regOperandPkg::*;
(
   input  operandReq_t        req,
   input  logic [`DATA_W-1:0] srcData,
   input  logic [`DATA_W-1:0] dstData,
   input  logic [`DATA_W-1:0] constVal,
   input  logic               constValid,
   output operand_t           operands
);

   logic [`DATA_W-1:0] srcWord;
   logic [`DATA_W-1:0] byteMask;

   // Constant overrides the register word
   assign srcWord = constValid ? constVal : srcData;

   // Low byte only in byte mode
   assign byteMask = {{(`DATA_W-8){~req.byteMode}}, 8'hFF};

   always_comb
   begin
      operands = '0;
      if (req.hasSource)
      begin
         operands.src        = srcWord & byteMask;
         operands.srcIsConst = constValid;
      end
      if (req.hasDest)
         operands.dst = dstData & byteMask;
   end

endmodule

// File: design/regFile.sv
// --------------------------------------------------
// Sixteen-entry register file with PC, SP and SR
// update strobes and two combinational read ports
// --------------------------------------------------
`include "regOperand_macros.svh"

module regFile
   import regOperandPkg::*;
(
   input  logic               clk,
   input  logic               rst,
   input  regWrite_t          wr,
   input  regNum_t            srcAddr,
   input  regNum_t            dstAddr,
   input  logic [`DATA_W-1:0] resetVector,
   input  logic [`DATA_W-1:0] pcNext,
   input  logic [`DATA_W-1:0] spNext,
   input  logic [`DATA_W-1:0] srNext,
   input  logic               pcUpdate,
   input  logic               spUpdate,
   input  logic               srUpdate,
   output logic [`DATA_W-1:0] srcData,
   output logic [`DATA_W-1:0] dstData,
   output logic [`DATA_W-1:0] pc,
   output logic [`DATA_W-1:0] sp,
   output logic [`DATA_W-1:0] sr
);

   logic [`DATA_W-1:0] pcReg;
   logic [`DATA_W-1:0] spReg;
   logic [`DATA_W-1:0] srReg;

   // R3 and up take general writes only
   logic [`DATA_W-1:0] gpr [`REG_CG2:`REG_COUNT-1];

   // All sixteen registers in read order
   logic [`DATA_W-1:0] regView [`REG_COUNT];

   logic wrPc;
   logic wrSp;
   logic wrSr;
   logic wrGpr;
   logic pcTargetValid;

   assign wrPc  = wr.en && (wr.addr == `REG_PC);
   assign wrSp  = wr.en && (wr.addr == `REG_SP);
   assign wrSr  = wr.en && (wr.addr == `REG_SR);
   assign wrGpr = wr.en && (wr.addr >= `REG_CG2);
   assign pcTargetValid = (wr.data >= `PC_MIN_VALID);

   // Program counter
   always_ff @(posedge clk)
   begin
      if (rst)
         pcReg <= resetVector;
      else if (wrPc)
         pcReg <= pcTargetValid ? wr.data : resetVector;
      else if (pcUpdate)
         pcReg <= pcNext;
   end

   // Stack pointer
   always_ff @(posedge clk)
   begin
      if (rst)
         spReg <= '0;
      else if (wrSp)
         spReg <= wr.data;
      else if (spUpdate)
         spReg <= spNext;
   end

   // Status register starts cleared so GIE is low
   always_ff @(posedge clk)
   begin
      if (rst)
         srReg <= '0;
      else if (wrSr)
         srReg <= wr.data;
      else if (srUpdate)
         srReg <= srNext;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = `REG_CG2; i < `REG_COUNT; i++)
            gpr[i] <= '0;
      end
      else if (wrGpr)
         gpr[wr.addr] <= wr.data;
   end

   always_comb
   begin
      regView[`REG_PC] = pcReg;
      regView[`REG_SP] = spReg;
      regView[`REG_SR] = srReg;
      for (int i = `REG_CG2; i < `REG_COUNT; i++)
         regView[i] = gpr[i];
   end

   // Reads see the stored value with no write bypass
   assign srcData = regView[srcAddr];
   assign dstData = regView[dstAddr];

   assign pc = pcReg;
   assign sp = spReg;
   assign sr = srReg;

endmodule

// File: design/regOperandPkg.sv
// --------------------------------------------------
// Shared types of the register operand stage
// --------------------------------------------------
`include "regOperand_macros.svh"

package regOperandPkg;

   typedef logic [$clog2(`REG_COUNT)-1:0] regNum_t;
   typedef logic [1:0] addrMode_t;

   // Double-operand view of the instruction word
   typedef struct packed {
      logic [3:0] opcode;
      regNum_t    srcReg;
      logic       ad;
      logic       byteFlag;
      addrMode_t  as;
      regNum_t    dstReg;
   } dualOpFields_t;

   // Single-operand view of the instruction word
   typedef struct packed {
      logic [5:0] prefix;
      logic [2:0] opcode;
      logic       byteFlag;
      addrMode_t  as;
      regNum_t    regNum;
   } singleOpFields_t;

   // One fetched word read both ways
   typedef union packed {
      dualOpFields_t   dualOp;
      singleOpFields_t singleOp;
   } instrWord_t;

   typedef struct packed {
      regNum_t   srcReg;
      regNum_t   dstReg;
      addrMode_t as;
      logic      byteMode;
      logic      hasSource;
      logic      hasDest;
   } operandReq_t;

   typedef struct packed {
      logic               en;
      regNum_t            addr;
      logic [`DATA_W-1:0] data;
   } regWrite_t;

   typedef struct packed {
      logic [`DATA_W-1:0] src;
      logic [`DATA_W-1:0] dst;
      logic               srcIsConst;
   } operand_t;

endpackage

// File: design/regOperandUnit.sv
// --------------------------------------------------
// Top level of the register and operand-source stage
// --------------------------------------------------
`include "regOperand_macros.svh"

module regOperandUnit
   import regOperandPkg::*;
(
   input  logic               clk,
   input  logic               rst,
   input  instrWord_t         instr,
   input  logic [`DATA_W-1:0] resetVector,
   input  regWrite_t          wr,
   input  logic [`DATA_W-1:0] pcNext,
   input  logic               pcUpdate,
   input  logic [`DATA_W-1:0] spNext,
   input  logic               spUpdate,
   input  logic [`DATA_W-1:0] srNext,
   input  logic               srUpdate,
   output operand_t           operands,
   output logic [`DATA_W-1:0] pc,
   output logic [`DATA_W-1:0] sp,
   output logic [`DATA_W-1:0] sr
);

   operandReq_t        req;
   logic [`DATA_W-1:0] srcData;
   logic [`DATA_W-1:0] dstData;
   logic [`DATA_W-1:0] constVal;
   logic               constValid;

   instrFieldDecode decode (
      .instr (instr),
      .req   (req)
   );

   regFile regs (
      .clk         (clk),
      .rst         (rst),
      .wr          (wr),
      .srcAddr     (req.srcReg),
      .dstAddr     (req.dstReg),
      .resetVector (resetVector),
      .pcNext      (pcNext),
      .spNext      (spNext),
      .srNext      (srNext),
      .pcUpdate    (pcUpdate),
      .spUpdate    (spUpdate),
      .srUpdate    (srUpdate),
      .srcData     (srcData),
      .dstData     (dstData),
      .pc          (pc),
      .sp          (sp),
      .sr          (sr)
   );

   // Runs beside the register file on the same source fields
   constGen constants (
      .srcReg     (req.srcReg),
      .as         (req.as),
      .constVal   (constVal),
      .constValid (constValid)
   );

   operandSelect select (
      .req        (req),
      .srcData    (srcData),
      .dstData    (dstData),
      .constVal   (constVal),
      .constValid (constValid),
      .operands   (operands)
   );

endmodule

// File: design/regOperand_macros.svh
// --------------------------------------------------
// Register operand stage constants for widths,
// special register numbers and the PC limit
// --------------------------------------------------
`ifndef REG_OPERAND_MACROS_SVH
`define REG_OPERAND_MACROS_SVH

// Operand and register width
`define DATA_W 16

// Size of the register file
`define REG_COUNT 16

// Special register numbers
`define REG_PC  4'd0
`define REG_SP  4'd1
`define REG_SR  4'd2
`define REG_CG2 4'd3

// Lowest legal program address
// PC writes below this load the reset vector
`define PC_MIN_VALID 16'h0200

`endif

// File: regOperandUnit.f
+incdir+design
design/regOperandPkg.sv
design/instrFieldDecode.sv
design/regFile.sv
design/constGen.sv
design/operandSelect.sv
design/regOperandUnit.sv
verif/regOperandUnitTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the register operand stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
   -f regOperandUnit.f \
   --top-module regOperandUnitTb

# The testbench ends with $fatal on an error, so the exit code is not used here
./obj_dir/VregOperandUnitTb > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
   echo "Simulation reported a failure"
   exit 1
fi
echo "Simulation finished without a failure"

// File: verif/regOperandUnitTb.sv
// --------------------------------------------------
// Testbench for the register operand stage driven
// from a command file and a register reference model
// --------------------------------------------------
`include "regOperand_macros.svh"

module regOperandUnitTb
   import regOperandPkg::*;
();

   localparam int CMD_LIMIT = 1000;
   localparam int RESET_TIMEOUT = 8;

   logic               clk;
   logic               rst;
   instrWord_t         instr;
   logic [`DATA_W-1:0] resetVector;
   regWrite_t          wr;
   logic [`DATA_W-1:0] pcNext;
   logic               pcUpdate;
   logic [`DATA_W-1:0] spNext;
   logic               spUpdate;
   logic [`DATA_W-1:0] srNext;
   logic               srUpdate;
   operand_t           operands;
   logic [`DATA_W-1:0] pc;
   logic [`DATA_W-1:0] sp;
   logic [`DATA_W-1:0] sr;

   // Reference copy of all sixteen registers
   logic [`DATA_W-1:0] model [`REG_COUNT];
   int                 fd;

   regOperandUnit UUT (
      .clk         (clk),
      .rst         (rst),
      .instr       (instr),
      .resetVector (resetVector),
      .wr          (wr),
      .pcNext      (pcNext),
      .pcUpdate    (pcUpdate),
      .spNext      (spNext),
      .spUpdate    (spUpdate),
      .srNext      (srNext),
      .srUpdate    (srUpdate),
      .operands    (operands),
      .pc          (pc),
      .sp          (sp),
      .sr          (sr)
   );

   always #2 clk = ~clk;

   task automatic failRun(input string why);
      $display("%s", why);
      $display("test failed");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic checkValue(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
      if (actual !== expected)
         failRun($sformatf("Error at time %0t: %s expected %h, got %h",
                           $time, name, expected, actual));
   endtask

   // Operands the register model predicts for one instruction word
   function automatic operand_t expectOperands(input logic [15:0] word);
      operand_t    res;
      logic [3:0]  srcNum;
      logic [3:0]  dstNum;
      logic [1:0]  mode;
      logic        byteOp;
      logic        isConst;
      logic [15:0] srcVal;
      res = '0;
      // Jump format has no register operands
      if (word[15:13] == 3'b001)
         return res;
      mode = word[5:4];
      byteOp = word[6];
      dstNum = word[3:0];
      srcNum = (word[15:10] == 6'b000100) ? word[3:0] : word[11:8];
      isConst = 1'b0;
      srcVal = model[srcNum];
      if (srcNum == 4'd2 && mode != 2'b00)
      begin
         isConst = 1'b1;
         srcVal = (mode == 2'b01) ? 16'h0000 : ((mode == 2'b10) ? 16'h0004 : 16'h0008);
      end
      else if (srcNum == 4'd3)
      begin
         isConst = 1'b1;
         case (mode)
            2'b00:   srcVal = 16'h0000;
            2'b01:   srcVal = 16'h0001;
            2'b10:   srcVal = 16'h0002;
            default: srcVal = 16'hFFFF;
         endcase
      end
      res.src = byteOp ? {8'h00, srcVal[7:0]} : srcVal;
      res.dst = byteOp ? {8'h00, model[dstNum][7:0]} : model[dstNum];
      res.srcIsConst = isConst;
      return res;
   endfunction

   // Apply the writes driven in this cycle as the coming edge will
   task automatic updateModel();
      if (wr.en && wr.addr == `REG_PC)
         model[`REG_PC] = (wr.data >= `PC_MIN_VALID) ? wr.data : resetVector;
      else if (pcUpdate)
         model[`REG_PC] = pcNext;
      if (wr.en && wr.addr == `REG_SP)
         model[`REG_SP] = wr.data;
      else if (spUpdate)
         model[`REG_SP] = spNext;
      if (wr.en && wr.addr == `REG_SR)
         model[`REG_SR] = wr.data;
      else if (srUpdate)
         model[`REG_SR] = srNext;
      if (wr.en && wr.addr >= `REG_CG2)
         model[wr.addr] = wr.data;
   endtask

   // Read the next command line and skip comments and blank lines
   task automatic readCommand(output logic found, output logic [7:0] cmd,
                              output logic [15:0] f1, output logic [15:0] f2,
                              output logic [15:0] f3, output logic [15:0] f4);
      string line;
      int    n;
      found = 1'b0;
      cmd = 8'h00;
      f1 = '0;
      f2 = '0;
      f3 = '0;
      f4 = '0;
      while (!found && !$feof(fd))
      begin
         n = $fgets(line, fd);
         if (n > 0 && line.len() > 1 && line[0] != "#")
         begin
            n = $sscanf(line, "%c %h %h %h %h", cmd, f1, f2, f3, f4);
            if (n != 5)
               failRun("A line of the test file could not be parsed");
            found = 1'b1;
         end
      end
   endtask

   // One cycle per command with the checks in mid-cycle
   task automatic runCommand(input logic [7:0] cmd, input logic [15:0] f1,
                             input logic [15:0] f2, input logic [15:0] f3,
                             input logic [15:0] f4);
      operand_t expected;
      @(posedge clk);
      #1;
      wr = '0;
      pcUpdate = 1'b0;
      spUpdate = 1'b0;
      srUpdate = 1'b0;
      case (cmd)
         "W":
         begin
            wr.en = 1'b1;
            wr.addr = f1[3:0];
            wr.data = f2;
            pcUpdate = f3[0];
            spUpdate = f3[1];
            srUpdate = f3[2];
            pcNext = f4;
            spNext = f4;
            srNext = f4;
         end
         "P":
         begin
            pcUpdate = 1'b1;
            pcNext = f1;
         end
         "S":
         begin
            spUpdate = 1'b1;
            spNext = f1;
         end
         "R":
         begin
            srUpdate = 1'b1;
            srNext = f1;
         end
         "I":     instr = f1;
         "C":     ;
         default: failRun("The test file holds an unknown command letter");
      endcase
      #2;
      if (cmd == "I")
      begin
         expected = expectOperands(f1);
         checkValue("operands.src", f2, operands.src);
         checkValue("operands.dst", f3, operands.dst);
         checkValue("operands.srcIsConst", f4, {15'b0, operands.srcIsConst});
         checkValue("operands.src vs model", expected.src, operands.src);
         checkValue("operands.dst vs model", expected.dst, operands.dst);
         checkValue("operands.srcIsConst vs model", {15'b0, expected.srcIsConst},
                    {15'b0, operands.srcIsConst});
      end
      else if (cmd == "C")
      begin
         checkValue("pc", f1, pc);
         checkValue("sp", f2, sp);
         checkValue("sr", f3, sr);
         checkValue("pc vs model", model[`REG_PC], pc);
         checkValue("sp vs model", model[`REG_SP], sp);
         checkValue("sr vs model", model[`REG_SR], sr);
      end
      updateModel();
   endtask

   initial
   begin
      logic        found;
      logic [7:0]  cmd;
      logic [15:0] f1;
      logic [15:0] f2;
      logic [15:0] f3;
      logic [15:0] f4;
      logic [31:0] randData;
      int          cmdCount;
      int          waitCycles;
      int          dstReg;
      logic [15:0] word;
      void'($urandom(32'h657e_fb20));
      clk = 1'b0;
      rst = 1'b1;
      instr = '0;
      resetVector = '0;
      wr = '0;
      pcNext = '0;
      pcUpdate = 1'b0;
      spNext = '0;
      spUpdate = 1'b0;
      srNext = '0;
      srUpdate = 1'b0;
      fd = $fopen("verif/regOperandUnit_tests.txt", "r");
      if (fd == 0)
         failRun("The test file could not be opened");
      readCommand(found, cmd, f1, f2, f3, f4);
      if (!found || cmd != "V")
         failRun("The test file does not start with a reset vector line");
      resetVector = f1;
      for (int i = 0; i < `REG_COUNT; i++)
         model[i] = '0;
      model[`REG_PC] = resetVector;

      // Reset held for two cycles
      for (int i = 0; i < 2; i++)
         @(posedge clk);
      #1;
      rst = 1'b0;
      waitCycles = 0;
      while (pc !== resetVector)
      begin
         @(posedge clk);
         #1;
         waitCycles++;
         if (waitCycles > RESET_TIMEOUT)
            failRun("The PC never loaded the reset vector after reset");
      end

      cmdCount = 0;
      found = 1'b1;
      while (found)
      begin
         readCommand(found, cmd, f1, f2, f3, f4);
         if (found)
            runCommand(cmd, f1, f2, f3, f4);
         cmdCount++;
         if (cmdCount > CMD_LIMIT)
            failRun("The test file loop ran past its command limit");
      end
      $fclose(fd);

      // Random data into R4 to R15 and read back
      for (int r = 4; r < `REG_COUNT; r++)
      begin
         randData = $urandom;
         runCommand("W", 16'(r), randData[15:0], 16'h0000, 16'h0000);
      end
      for (int r = 4; r < `REG_COUNT; r++)
      begin
         dstReg = (r == 15) ? 4 : r + 1;
         word = {4'h4, 4'(r), 4'h0, 4'(dstReg)};
         runCommand("I", word, model[r], model[dstReg], 16'h0000);
      end

      $display("test passed");
      $finish;
   end

endmodule

// File: verif/regOperandUnit_tests.txt
# Columns: cmd f1 f2 f3 f4, all hex. V: reset vector. W: reg data updMask(1 PC 2 SP 4 SR) updValue
# P/S/R: update value. I: instr expSrc expDst expSrcIsConst. C: expPc expSp expSr
V 0400 0000 0000 0000
# State right after reset
C 0400 0000 0000 0000
I 4404 0000 0000 0000
# General writes, double and single operand reads
W 0004 1234 0000 0000
W 0005 abcd 0000 0000
I 4405 1234 abcd 0000
I 1004 1234 1234 0000
I 1185 abcd abcd 0000
# Constant generator, R2 and R3
I 4214 0000 1234 0001
I 4224 0004 1234 0001
I 4234 0008 1234 0001
I 4304 0000 1234 0001
I 4314 0001 1234 0001
I 4324 0002 1234 0001
I 4334 ffff 1234 0001
R 0123 0000 0000 0000
I 4204 0123 1234 0000
I 1003 0000 0000 0001
# Byte mode and jumps
I 4445 0034 00cd 0000
I 4374 00ff 0034 0001
I 1044 0034 0034 0000
I 2c05 0000 0000 0000
I 3fff 0000 0000 0000
# PC writes, limit and strobes
I 4005 0400 abcd 0000
W 0000 0800 0000 0000
C 0800 0000 0123 0000
W 0000 0200 0000 0000
C 0200 0000 0123 0000
W 0000 01ff 0000 0000
C 0400 0000 0123 0000
P 0a00 0000 0000 0000
S 1ff0 0000 0000 0000
C 0a00 1ff0 0123 0000
# General write beats the update strobe
W 0000 0600 0001 0c00
W 0001 2000 0002 3000
W 0002 0055 0004 00aa
C 0600 2000 0055 0000
I 4104 2000 1234 0000
W 0000 0100 0001 0c00
C 0400 2000 0055 0000
